/* Makefile */
# Verilator flow for the transport stream capture project.

TOP = ts_capture_tb
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f all.f

sim:
	verilator --binary --assert --top-module $(TOP) -f all.f -o ts_capture_sim
	./obj_dir/ts_capture_sim | tee $(LOG)
	grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* all.f */
+incdir+logic
logic/ts_capture_pkg.sv
logic/ts_word_packer.sv
logic/ts_sync_monitor.sv
logic/ts_capture_buffer.sv
logic/ts_capture_top.sv
test/ts_capture_chk.sv
test/ts_capture_tb.sv

/* logic/ts_capture_buffer.sv */
`default_nettype none

`include "ts_capture_defines.svh"

module ts_capture_buffer (
	input logic ts_clk,
	input logic rst_n,
	input ts_capture_pkg::ts_word_t word,
	input logic word_valid,
	input ts_capture_pkg::ts_status_t status,
	output logic counters_clear,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input logic [2:0] wb_adr,
	input logic [31:0] wb_dat_w,
	output logic [31:0] wb_dat_r,
	output logic wb_ack
);

	localparam int PTR_W = $clog2(`TS_FIFO_DEPTH);

	ts_capture_pkg::ts_word_t mem [`TS_FIFO_DEPTH];
	ts_capture_pkg::ts_word_t head;
	ts_capture_pkg::ts_reg_e reg_sel;

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0] level;
	logic [15:0] overflow;
	logic [31:0] rd_value;
	logic access;
	logic push;
	logic pop;

	assign reg_sel = ts_capture_pkg::ts_reg_e'(wb_adr);
	assign head = mem[rd_ptr];

	// new access only while ack is low, so one per two cycles.
	assign access = wb_cyc && wb_stb && !wb_ack;

	// full fifo drops the incoming word.
	assign push = word_valid && (level != (PTR_W + 1)'(`TS_FIFO_DEPTH));
	assign pop = access && !wb_we && (reg_sel == ts_capture_pkg::REG_DATA) && (level != '0);

	// ########################################
	// word fifo.
	// ########################################

	always_ff @(posedge ts_clk) begin
		if (push) begin
			mem[wr_ptr] <= word;
		end
	end

	always_ff @(posedge ts_clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10: level <= level + 1'b1;
				2'b01: level <= level - 1'b1;
				default: level <= level;
			endcase
		end
	end

	always_ff @(posedge ts_clk) begin
		if (!rst_n) begin
			overflow <= '0;
		end else if (counters_clear) begin
			overflow <= '0;
		end else if (word_valid && !push && overflow != 16'hffff) begin
			overflow <= overflow + 16'd1;
		end
	end

	// ########################################
	// wishbone slave.
	// ########################################

	// head fields read as zero when nothing is queued.
	always_comb begin
		rd_value = '0;
		case (reg_sel)
			ts_capture_pkg::REG_DATA: begin
				if (level != '0) begin
					rd_value = head.data;
				end
			end
			ts_capture_pkg::REG_INFO: begin
				rd_value[PTR_W:0] = level;
				if (level != '0) begin
					rd_value[10:8] = head.count;
					rd_value[12] = head.first;
				end
			end
			ts_capture_pkg::REG_PACKETS: rd_value[15:0] = status.packets;
			ts_capture_pkg::REG_SYNC_ERR: rd_value[15:0] = status.sync_errors;
			ts_capture_pkg::REG_LEN_ERR: rd_value[15:0] = status.length_errors;
			ts_capture_pkg::REG_OVERFLOW: rd_value[15:0] = overflow;
			default: rd_value = '0;
		endcase
	end

	always_ff @(posedge ts_clk) begin
		if (!rst_n) begin
			wb_ack <= 1'b0;
			counters_clear <= 1'b0;
		end else begin
			wb_ack <= access;
			counters_clear <= access && wb_we && (reg_sel == ts_capture_pkg::REG_CLEAR);
		end
	end

	always_ff @(posedge ts_clk) begin
		if (access && !wb_we) begin
			wb_dat_r <= rd_value;
		end
	end

endmodule

`default_nettype wire

/* logic/ts_capture_defines.svh */
`ifndef TS_CAPTURE_DEFINES_SVH
`define TS_CAPTURE_DEFINES_SVH

// ########################################
// stream format.
// ########################################

`define TS_BYTE_W 8
`define TS_WORD_W 32
`define TS_PACKET_LEN 188
`define TS_SYNC_BYTE 8'h47

// ########################################
// capture buffer.
// ########################################

// number of packed words held for the host.
`define TS_FIFO_DEPTH 16

`endif

/* logic/ts_capture_pkg.sv */
`default_nettype none

`include "ts_capture_defines.svh"

package ts_capture_pkg;

	// one beat of the incoming stream.
	typedef struct packed {
		logic valid;
		logic sync;
		logic [`TS_BYTE_W-1:0] data;
	} ts_byte_t;

	// packed word, byte 0 sits in the low bits.
	typedef struct packed {
		logic [`TS_WORD_W-1:0] data;
		logic [2:0] count;
		logic first;
	} ts_word_t;

	// framing counters from the monitor.
	typedef struct packed {
		logic [15:0] packets;
		logic [15:0] sync_errors;
		logic [15:0] length_errors;
	} ts_status_t;

	// ########################################
	// register map.
	// ########################################

	typedef enum logic [2:0] {
		REG_DATA = 3'd0,
		REG_INFO = 3'd1,
		REG_PACKETS = 3'd2,
		REG_SYNC_ERR = 3'd3,
		REG_LEN_ERR = 3'd4,
		REG_OVERFLOW = 3'd5,
		REG_CLEAR = 3'd6
	} ts_reg_e;

endpackage

`default_nettype wire

/* logic/ts_capture_top.sv */
`default_nettype none

`include "ts_capture_defines.svh"

module ts_capture_top (
	input logic ts_clk,
	input logic rst_n,
	input logic ts_valid,
	input logic ts_sync,
	input logic [`TS_BYTE_W-1:0] ts_data,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input logic [2:0] wb_adr,
	input logic [31:0] wb_dat_w,
	output logic [31:0] wb_dat_r,
	output logic wb_ack
);

	ts_capture_pkg::ts_byte_t stream;
	ts_capture_pkg::ts_word_t word;
	ts_capture_pkg::ts_status_t status;
	logic word_valid;
	logic counters_clear;

	// both blocks see the same bytes.
	assign stream.valid = ts_valid;
	assign stream.sync = ts_sync;
	assign stream.data = ts_data;

	ts_word_packer u_packer (
		.ts_clk(ts_clk),
		.rst_n(rst_n),
		.stream(stream),
		.word(word),
		.word_valid(word_valid)
	);

	ts_sync_monitor u_monitor (
		.ts_clk(ts_clk),
		.rst_n(rst_n),
		.stream(stream),
		.counters_clear(counters_clear),
		.status(status)
	);

	ts_capture_buffer u_buffer (
		.ts_clk(ts_clk),
		.rst_n(rst_n),
		.word(word),
		.word_valid(word_valid),
		.status(status),
		.counters_clear(counters_clear),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w),
		.wb_dat_r(wb_dat_r),
		.wb_ack(wb_ack)
	);

endmodule

`default_nettype wire

/* logic/ts_sync_monitor.sv */
`default_nettype none

`include "ts_capture_defines.svh"

module ts_sync_monitor (
	input logic ts_clk,
	input logic rst_n,
	input ts_capture_pkg::ts_byte_t stream,
	input logic counters_clear,
	output ts_capture_pkg::ts_status_t status
);

	// one bit of headroom so an overlong packet is still seen.
	localparam int LEN_W = $clog2(`TS_PACKET_LEN) + 1;

	logic [LEN_W-1:0] pkt_len;
	logic pkt_open;
	logic sync_seen;
	logic bad_sync;
	logic bad_len;

	function automatic logic [15:0] sat_inc(input logic [15:0] value);
		return (value == 16'hffff) ? value : value + 16'd1;
	endfunction

	assign sync_seen = stream.valid && stream.sync;
	assign bad_sync = stream.data != `TS_SYNC_BYTE;
	assign bad_len = pkt_open && (pkt_len != LEN_W'(`TS_PACKET_LEN));

	// ########################################
	// packet length tracking.
	// ########################################

	always_ff @(posedge ts_clk) begin
		if (!rst_n) begin
			pkt_len <= '0;
			pkt_open <= 1'b0;
		end else if (stream.valid) begin
			if (stream.sync) begin
				pkt_len <= LEN_W'(1);
				pkt_open <= 1'b1;
			end else if (pkt_open && pkt_len != '1) begin
				pkt_len <= pkt_len + 1'b1;
			end
		end
	end

	// ########################################
	// counters.
	// ########################################

	// clear leaves the open packet alone.
	always_ff @(posedge ts_clk) begin
		if (!rst_n) begin
			status <= '0;
		end else if (counters_clear) begin
			status <= '0;
		end else if (sync_seen) begin
			status.packets <= sat_inc(status.packets);
			if (bad_sync) begin
				status.sync_errors <= sat_inc(status.sync_errors);
			end
			if (bad_len) begin
				status.length_errors <= sat_inc(status.length_errors);
			end
		end
	end

endmodule

`default_nettype wire

/* logic/ts_word_packer.sv */
`default_nettype none

`include "ts_capture_defines.svh"

module ts_word_packer (
	input logic ts_clk,
	input logic rst_n,
	input ts_capture_pkg::ts_byte_t stream,
	output ts_capture_pkg::ts_word_t word,
	output logic word_valid
);

	logic [1:0] lane;
	logic acc_first;
	logic [`TS_WORD_W-1:0] acc_data;
	logic [`TS_WORD_W-1:0] lane_data;
	logic close_early;
	logic close_full;

	// a sync byte closes whatever partial word is held.
	assign close_early = stream.valid && stream.sync && (lane != 2'd0);
	assign close_full = stream.valid && !close_early && (lane == 2'd3);

	// incoming byte moved into its lane.
	assign lane_data = `TS_WORD_W'(stream.data) << (lane * `TS_BYTE_W);

	// ########################################
	// lane tracking.
	// ########################################

	always_ff @(posedge ts_clk) begin
		if (!rst_n) begin
			lane <= 2'd0;
			acc_first <= 1'b0;
			word_valid <= 1'b0;
		end else begin
			word_valid <= close_early || close_full;
			if (stream.valid) begin
				if (close_early) begin
					// sync byte already sits in lane 0.
					lane <= 2'd1;
					acc_first <= 1'b1;
				end else begin
					lane <= lane + 2'd1;
					if (lane == 2'd0) begin
						acc_first <= stream.sync;
					end
				end
			end
		end
	end

	// ########################################
	// word assembly.
	// ########################################

	always_ff @(posedge ts_clk) begin
		if (close_early) begin
			word.data <= acc_data;
			word.count <= {1'b0, lane};
			word.first <= acc_first;
		end else if (close_full) begin
			word.data <= acc_data | lane_data;
			word.count <= 3'd4;
			word.first <= acc_first;
		end

		// a new word starts from zero, so unused lanes stay clear.
		if (stream.valid) begin
			if (close_early || lane == 2'd0) begin
				acc_data <= `TS_WORD_W'(stream.data);
			end else begin
				acc_data <= acc_data | lane_data;
			end
		end
	end

endmodule

`default_nettype wire

/* test/ts_capture_chk.sv */
`default_nettype none

`include "ts_capture_defines.svh"

module ts_capture_chk (
	input logic ts_clk,
	input logic rst_n,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_ack,
	input logic [$clog2(`TS_FIFO_DEPTH):0] level
);

	localparam int LVL_W = $clog2(`TS_FIFO_DEPTH) + 1;

	// ########################################
	// wishbone handshake.
	// ########################################

	// ack is registered, so the request sits one edge before it.
	ack_needs_request: assert property (@(posedge ts_clk) disable iff (!rst_n)
		$rose(wb_ack) |-> $past(wb_cyc && wb_stb))
		else $error("wb_ack rose without cyc and stb");

	ack_one_cycle: assert property (@(posedge ts_clk) disable iff (!rst_n)
		wb_ack |=> !wb_ack)
		else $error("wb_ack held high for two cycles");

	// reset must leave the bus idle.
	ack_low_after_reset: assert property (@(posedge ts_clk)
		!rst_n |=> !wb_ack)
		else $error("wb_ack high in the cycle after reset");

	// ########################################
	// fifo level.
	// ########################################

	level_in_range: assert property (@(posedge ts_clk) disable iff (!rst_n)
		level <= LVL_W'(`TS_FIFO_DEPTH))
		else $error("fifo level above depth");

endmodule

bind ts_capture_buffer ts_capture_chk u_chk (
	.ts_clk(ts_clk),
	.rst_n(rst_n),
	.wb_cyc(wb_cyc),
	.wb_stb(wb_stb),
	.wb_ack(wb_ack),
	.level(level)
);

`default_nettype wire

/* test/ts_capture_tb.sv */
`default_nettype none

`include "ts_capture_defines.svh"

module ts_capture_tb;

	localparam int IDLE = 4;
	// ten packets are driven. each word costs two reads of about two cycles.
	localparam int PKTS = 10;
	localparam int STIM_LEN = PKTS * (`TS_PACKET_LEN + IDLE);
	localparam int READ_LEN = PKTS * ((`TS_PACKET_LEN / 4) * 2 + 8) * 2;
	localparam int CYCLE_LIMIT = 2 * (STIM_LEN + READ_LEN);

	logic ts_clk;
	logic rst_n;
	logic ts_valid;
	logic ts_sync;
	logic [`TS_BYTE_W-1:0] ts_data;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [2:0] wb_adr;
	logic [31:0] wb_dat_w;
	logic [31:0] wb_dat_r;
	logic wb_ack;

	logic [31:0] rng;
	int cycles = 0;
	int checks = 0;
	int errors = 0;
	int test_errors = 0;
	int tests = 0;

	// reference model state.
	ts_capture_pkg::ts_word_t exp_q[$];
	logic [31:0] m_acc;
	int m_lane;
	logic m_first;
	int m_len;
	logic m_open;
	int m_packets;
	int m_sync_err;
	int m_len_err;
	int m_overflow;

	ts_capture_top DUT (
		.ts_clk(ts_clk),
		.rst_n(rst_n),
		.ts_valid(ts_valid),
		.ts_sync(ts_sync),
		.ts_data(ts_data),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w),
		.wb_dat_r(wb_dat_r),
		.wb_ack(wb_ack)
	);

	initial begin
		ts_clk = 1'b0;
		forever #20 ts_clk = ~ts_clk;
	end

	always @(posedge ts_clk) begin
		cycles = cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("=== FAIL ===");
			$finish;
		end
	end

	function automatic logic [31:0] next_rand();
		logic [31:0] x;
		x = rng;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng = x;
		return x;
	endfunction

	// ########################################
	// reference model.
	// ########################################

	function automatic void push_word(input int count);
		ts_capture_pkg::ts_word_t w;
		w.data = m_acc;
		w.count = 3'(count);
		w.first = m_first;
		if (exp_q.size() < `TS_FIFO_DEPTH) begin
			exp_q.push_back(w);
		end else begin
			m_overflow++;
		end
		m_acc = '0;
		m_lane = 0;
	endfunction

	function automatic void model_byte(input logic sync, input logic [7:0] data);
		if (sync) begin
			m_packets++;
			if (data != `TS_SYNC_BYTE) begin
				m_sync_err++;
			end
			if (m_open && m_len != `TS_PACKET_LEN) begin
				m_len_err++;
			end
			m_open = 1'b1;
			m_len = 1;
			// a packet start closes the partial word.
			if (m_lane != 0) begin
				push_word(m_lane);
			end
		end else if (m_open) begin
			m_len++;
		end
		if (m_lane == 0) begin
			m_first = sync;
		end
		m_acc[m_lane*8 +: 8] = data;
		m_lane++;
		if (m_lane == 4) begin
			push_word(4);
		end
	endfunction

	function automatic logic [31:0] info_value(input int level, input ts_capture_pkg::ts_word_t w);
		logic [31:0] v;
		v = 32'(level);
		v[10:8] = w.count;
		v[12] = w.first;
		return v;
	endfunction

	// ########################################
	// stimulus and bus tasks.
	// ########################################

	task automatic send_byte(input logic sync, input logic [7:0] data);
		@(negedge ts_clk);
		ts_valid = 1'b1;
		ts_sync = sync;
		ts_data = data;
		model_byte(sync, data);
	endtask

	task automatic send_packet(input int len, input logic good);
		logic [31:0] r;
		logic [7:0] first_byte;
		r = next_rand();
		first_byte = r[7:0];
		if (good) begin
			first_byte = `TS_SYNC_BYTE;
		end else if (first_byte == `TS_SYNC_BYTE) begin
			first_byte = ~first_byte;
		end
		send_byte(1'b1, first_byte);
		for (int i = 1; i < len; i++) begin
			r = next_rand();
			send_byte(1'b0, r[7:0]);
		end
	endtask

	// long enough for the last word to reach the fifo.
	task automatic stream_idle();
		@(negedge ts_clk);
		ts_valid = 1'b0;
		ts_sync = 1'b0;
		ts_data = '0;
		repeat (IDLE) @(negedge ts_clk);
	endtask

	task automatic wb_access(input logic we, input ts_capture_pkg::ts_reg_e adr,
		input logic [31:0] wdata, output logic [31:0] rdata);
		@(negedge ts_clk);
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = adr;
		wb_dat_w = wdata;
		do begin
			@(negedge ts_clk);
		end while (!wb_ack);
		rdata = wb_dat_r;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
	endtask

	task automatic check_reg(input ts_capture_pkg::ts_reg_e adr, input logic [31:0] exp);
		logic [31:0] got;
		wb_access(1'b0, adr, 32'd0, got);
		checks++;
		assert (got == exp) else begin
			$display("mismatch at %0t: %s read %h, expected %h", $time, adr.name(), got, exp);
			test_errors++;
		end
	endtask

	task automatic check_counters();
		check_reg(ts_capture_pkg::REG_PACKETS, 32'(m_packets));
		check_reg(ts_capture_pkg::REG_SYNC_ERR, 32'(m_sync_err));
		check_reg(ts_capture_pkg::REG_LEN_ERR, 32'(m_len_err));
		check_reg(ts_capture_pkg::REG_OVERFLOW, 32'(m_overflow));
	endtask

	task automatic drain_fifo();
		ts_capture_pkg::ts_word_t w;
		while (exp_q.size() > 0) begin
			w = exp_q[0];
			check_reg(ts_capture_pkg::REG_INFO, info_value(exp_q.size(), w));
			check_reg(ts_capture_pkg::REG_DATA, w.data);
			w = exp_q.pop_front();
		end
		// empty fifo reads zero and does not pop.
		check_reg(ts_capture_pkg::REG_INFO, 32'd0);
		check_reg(ts_capture_pkg::REG_DATA, 32'd0);
	endtask

	task automatic finish_test(input string name);
		tests++;
		$display("test %0d %s: %0d errors", tests, name, test_errors);
		errors += test_errors;
		test_errors = 0;
	endtask

	// ########################################
	// tests.
	// ########################################

	initial begin
		int short_len;
		logic [31:0] r;
		logic [31:0] dummy;
		rng = 32'd98174;
		rst_n = 1'b0;
		ts_valid = 1'b0;
		ts_sync = 1'b0;
		ts_data = '0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = '0;
		wb_dat_w = '0;
		m_acc = '0;
		m_lane = 0;
		m_first = 1'b0;
		m_len = 0;
		m_open = 1'b0;
		m_packets = 0;
		m_sync_err = 0;
		m_len_err = 0;
		m_overflow = 0;
		repeat (3) @(negedge ts_clk);
		rst_n = 1'b1;

		check_reg(ts_capture_pkg::REG_DATA, 32'd0);
		check_reg(ts_capture_pkg::REG_INFO, 32'd0);
		check_counters();
		finish_test("reset values");

		for (int p = 0; p < 3; p++) begin
			send_packet(`TS_PACKET_LEN, 1'b1);
			stream_idle();
			drain_fifo();
			check_counters();
		end
		finish_test("good packets");

		// length never a multiple of four, so the last word is partial.
		// short enough that the partial word still fits in the fifo.
		r = next_rand();
		short_len = 5 + int'(r % 52);
		if (short_len % 4 == 0) begin
			short_len++;
		end
		send_packet(short_len, 1'b1);
		send_packet(`TS_PACKET_LEN, 1'b1);
		stream_idle();
		drain_fifo();
		check_counters();
		finish_test("short packet");

		send_packet(`TS_PACKET_LEN, 1'b0);
		stream_idle();
		drain_fifo();
		check_counters();
		finish_test("bad sync byte");

		for (int p = 0; p < 3; p++) begin
			send_packet(`TS_PACKET_LEN, 1'b1);
		end
		stream_idle();
		check_counters();
		drain_fifo();
		finish_test("fifo overflow");

		send_packet(`TS_PACKET_LEN, 1'b1);
		stream_idle();
		wb_access(1'b1, ts_capture_pkg::REG_CLEAR, 32'd1, dummy);
		m_packets = 0;
		m_sync_err = 0;
		m_len_err = 0;
		m_overflow = 0;
		check_counters();
		drain_fifo();
		finish_test("counter clear");

		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire
